/* src/ingress_config.svh */
/* Ingress aggregator configuration
   Port counts, converged bus width, FIFO depth and counter width */

`ifndef INGRESS_CONFIG_SVH
`define INGRESS_CONFIG_SVH

// Physical port groups
`define ING_NUM_8B_PORTS    2
`define ING_NUM_32B_PORTS   2

// 8-bit ports take indices 0 and 1, 32-bit ports follow
`define ING_NUM_PORTS       4

// Converged bus word in bytes
`define ING_BUS_BYTES       8

// Words per port buffer
`define ING_FIFO_DEPTH      64

// Statistics counter width
`define ING_CNT_WIDTH       16

`endif

/* src/ingress_pkg.sv */
/* Ingress aggregator shared types
   Converged bus word with byte and lane views, keep mask, port index, counter */

`include "ingress_config.svh"

package ingress_pkg;

    // One converged word, filled bytewise by 8-bit ports or lanewise by 32-bit ports
    typedef union packed {
        logic [`ING_BUS_BYTES-1:0][7:0]    bytes;
        logic [`ING_BUS_BYTES/4-1:0][31:0] lanes;
    } bus_word_u;

    // Byte valid mask of a converged word
    typedef logic [`ING_BUS_BYTES-1:0] keep_t;

    // Source port tag carried with every output word
    typedef logic [$clog2(`ING_NUM_PORTS)-1:0] port_idx_t;

    // Statistics counter
    typedef logic [`ING_CNT_WIDTH-1:0] cnt_t;

endpackage

/* src/lane_packer.sv */
/* Lane packer
   Packs narrow port beats into converged words and drops disabled frames */

`timescale 1ns/1ps

module lane_packer
    import ingress_pkg::*;
#(
    parameter int IN_BYTES = 1
) (
    input  logic                  clk_ifc,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  in_valid,
    input  logic [IN_BYTES*8-1:0] in_data,
    input  logic                  in_last,
    output logic                  word_valid,
    output bus_word_u             word,
    output keep_t                 word_keep,
    output logic                  word_last
);

    localparam int SLOTS = $bits(keep_t) / IN_BYTES;
    localparam int POS_W = $clog2(SLOTS);

    logic             in_frame;
    logic             skip;
    logic [POS_W-1:0] pos;
    bus_word_u        acc_word;
    keep_t            acc_keep;
    bus_word_u        fill_word;
    keep_t            fill_keep;
    logic             accept;

    // Enable only matters on the first beat, later beats follow that decision
    assign accept    = in_valid && (in_frame ? !skip : enable);
    assign fill_keep = acc_keep | (keep_t'({IN_BYTES{1'b1}}) << (pos * IN_BYTES));

    generate
        if (IN_BYTES == 1) begin : g_bytes
            always_comb begin
                fill_word = acc_word;
                fill_word.bytes[pos] = in_data;
            end
        end else begin : g_lanes
            always_comb begin
                fill_word = acc_word;
                fill_word.lanes[pos] = in_data;
            end
        end
    endgenerate

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            in_frame   <= 1'b0;
            skip       <= 1'b0;
            pos        <= '0;
            acc_keep   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (in_valid) begin
                in_frame <= !in_last;
                if (!in_frame) skip <= !enable;
            end
            if (accept) begin
                if (in_last || pos == POS_W'(SLOTS - 1)) begin
                    // Word full or frame ends here
                    word_valid <= 1'b1;
                    pos        <= '0;
                    acc_keep   <= '0;
                end else begin
                    pos      <= pos + 1'b1;
                    acc_keep <= fill_keep;
                end
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            acc_word  <= fill_word;
            word      <= fill_word;
            word_keep <= fill_keep;
            word_last <= in_last;
        end
    end

endmodule

/* src/frame_fifo.sv */
/* Frame FIFO
   Per-port word buffer that releases only complete frames and drops a frame on overflow */

`timescale 1ns/1ps

`include "ingress_config.svh"

module frame_fifo
    import ingress_pkg::*;
(
    input  logic      clk_ifc,
    input  logic      rst_n,
    input  logic      wr_valid,
    input  bus_word_u wr_word,
    input  keep_t     wr_keep,
    input  logic      wr_last,
    input  logic      rd_en,
    output logic      frame_ready,
    output bus_word_u rd_word,
    output keep_t     rd_keep,
    output logic      rd_last,
    output logic      overflow
);

    localparam int DEPTH = `ING_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    bus_word_u        mem_word [DEPTH];
    keep_t            mem_keep [DEPTH];
    logic [DEPTH-1:0] mem_last;

    // Pointers carry one extra bit to tell full from empty
    logic [AW:0] rd_ptr;
    logic [AW:0] wr_commit;
    logic [AW:0] wr_spec;
    logic [AW:0] frame_count;
    logic        discarding;
    logic        full;
    logic        wr_ok;
    logic        commit;
    logic        release_frame;

    assign full          = (wr_spec - rd_ptr) == (AW + 1)'(DEPTH);
    assign wr_ok         = wr_valid && !discarding && !full;
    assign commit        = wr_ok && wr_last;
    assign release_frame = rd_en && rd_last;

    assign frame_ready = frame_count != '0;
    assign rd_word     = mem_word[rd_ptr[AW-1:0]];
    assign rd_keep     = mem_keep[rd_ptr[AW-1:0]];
    assign rd_last     = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            wr_commit   <= '0;
            wr_spec     <= '0;
            frame_count <= '0;
            discarding  <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (wr_valid && discarding) begin
                if (wr_last) discarding <= 1'b0;
            end else if (wr_valid && full) begin
                // Rewind the partial frame and skip the rest of it
                wr_spec    <= wr_commit;
                discarding <= !wr_last;
                overflow   <= 1'b1;
            end else if (wr_ok) begin
                wr_spec <= wr_spec + 1'b1;
                if (wr_last) wr_commit <= wr_spec + 1'b1;
            end
            case ({commit, release_frame})
                2'b10:   frame_count <= frame_count + 1'b1;
                2'b01:   frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (wr_ok) begin
            mem_word[wr_spec[AW-1:0]] <= wr_word;
            mem_keep[wr_spec[AW-1:0]] <= wr_keep;
            mem_last[wr_spec[AW-1:0]] <= wr_last;
        end
    end

endmodule

/* src/frame_arbiter.sv */
/* Frame arbiter
   Round-robin merge of whole frames onto the converged bus, tagged with the source port */

`timescale 1ns/1ps

`include "ingress_config.svh"

module frame_arbiter
    import ingress_pkg::*;
(
    input  logic                      clk_ifc,
    input  logic                      rst_n,
    input  logic [`ING_NUM_PORTS-1:0] frame_ready,
    input  bus_word_u                 rd_word [`ING_NUM_PORTS],
    input  keep_t                     rd_keep [`ING_NUM_PORTS],
    input  logic [`ING_NUM_PORTS-1:0] rd_last,
    output logic [`ING_NUM_PORTS-1:0] rd_en,
    output logic                      out_valid,
    output bus_word_u                 out_data,
    output keep_t                     out_keep,
    output logic                      out_last,
    output port_idx_t                 out_port
);

    localparam int N = `ING_NUM_PORTS;

    logic      busy;
    port_idx_t grant;
    port_idx_t last_grant;
    port_idx_t pick;
    logic      found;

    ////////////////////////////////////////////////////////////
    // Round-robin search, starting after the last granted port
    ////////////////////////////////////////////////////////////

    always_comb begin
        int cand;
        pick  = last_grant;
        found = 1'b0;
        for (int i = 1; i <= N; i++) begin
            cand = (int'(last_grant) + i) % N;
            if (!found && frame_ready[cand]) begin
                pick  = port_idx_t'(cand);
                found = 1'b1;
            end
        end
    end

    // One pop per cycle for the whole granted frame
    assign rd_en = busy ? (N)'(1) << grant : '0;

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            grant      <= '0;
            last_grant <= port_idx_t'(N - 1);
            out_valid  <= 1'b0;
        end else begin
            out_valid <= busy;
            if (!busy) begin
                if (found) begin
                    busy  <= 1'b1;
                    grant <= pick;
                end
            end else if (rd_last[grant]) begin
                busy       <= 1'b0;
                last_grant <= grant;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        out_data <= rd_word[grant];
        out_keep <= rd_keep[grant];
        out_last <= rd_last[grant];
        out_port <= grant;
    end

endmodule

/* src/port_stats.sv */
/* Port statistics
   Saturating accepted-frame and dropped-frame counters per port with clear */

`timescale 1ns/1ps

`include "ingress_config.svh"

module port_stats
    import ingress_pkg::*;
(
    input  logic                      clk_ifc,
    input  logic                      rst_n,
    input  logic [`ING_NUM_PORTS-1:0] frame_seen,
    input  logic [`ING_NUM_PORTS-1:0] drop_seen,
    input  logic [`ING_NUM_PORTS-1:0] cnts_clear,
    output cnt_t                      frame_cnt [`ING_NUM_PORTS],
    output cnt_t                      drop_cnt  [`ING_NUM_PORTS]
);

    // Hold at all ones
    function automatic cnt_t sat_inc(input cnt_t c);
        return (c == '1) ? c : c + 1'b1;
    endfunction

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                frame_cnt[p] <= '0;
                drop_cnt[p]  <= '0;
            end
        end else begin
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                // Clear beats a same-cycle event
                if (cnts_clear[p]) begin
                    frame_cnt[p] <= '0;
                    drop_cnt[p]  <= '0;
                end else begin
                    if (frame_seen[p]) frame_cnt[p] <= sat_inc(frame_cnt[p]);
                    if (drop_seen[p]) drop_cnt[p] <= sat_inc(drop_cnt[p]);
                end
            end
        end
    end

endmodule

/* src/ingress_aggregator.sv */
/* Ingress aggregator top
   Packers, frame FIFOs and round-robin arbiter onto one converged bus, plus port counters */

`timescale 1ns/1ps

`include "ingress_config.svh"

module ingress_aggregator
    import ingress_pkg::*;
(
    input  logic                                 clk_ifc,
    input  logic                                 rst_n,
    input  logic [`ING_NUM_PORTS-1:0]            ports_enable,
    input  logic [`ING_NUM_PORTS-1:0]            cnts_clear,
    input  logic [`ING_NUM_8B_PORTS-1:0]         in8_valid,
    input  logic [`ING_NUM_8B_PORTS-1:0][7:0]    in8_data,
    input  logic [`ING_NUM_8B_PORTS-1:0]         in8_last,
    input  logic [`ING_NUM_32B_PORTS-1:0]        in32_valid,
    input  logic [`ING_NUM_32B_PORTS-1:0][31:0]  in32_data,
    input  logic [`ING_NUM_32B_PORTS-1:0]        in32_last,
    output logic                                 out_valid,
    output bus_word_u                            out_data,
    output keep_t                                out_keep,
    output logic                                 out_last,
    output port_idx_t                            out_port,
    output cnt_t                                 frame_cnt [`ING_NUM_PORTS],
    output cnt_t                                 drop_cnt  [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0]            buf_overflow
);

    localparam int N8 = `ING_NUM_8B_PORTS;

    logic [`ING_NUM_PORTS-1:0] pk_valid;
    bus_word_u                 pk_word [`ING_NUM_PORTS];
    keep_t                     pk_keep [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] pk_last;
    logic [`ING_NUM_PORTS-1:0] ff_ready;
    bus_word_u                 ff_word [`ING_NUM_PORTS];
    keep_t                     ff_keep [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] ff_last;
    logic [`ING_NUM_PORTS-1:0] ff_rd_en;
    logic [`ING_NUM_PORTS-1:0] frame_seen;

    // A packed last word is one accepted frame
    assign frame_seen = pk_valid & pk_last;

    for (genvar p = 0; p < N8; p++) begin : g_pack8
        lane_packer #(.IN_BYTES(1)) lane_packer_inst (
            .clk_ifc(clk_ifc), .rst_n(rst_n), .enable(ports_enable[p]),
            .in_valid(in8_valid[p]), .in_data(in8_data[p]), .in_last(in8_last[p]),
            .word_valid(pk_valid[p]), .word(pk_word[p]),
            .word_keep(pk_keep[p]), .word_last(pk_last[p])
        );
    end

    for (genvar p = 0; p < `ING_NUM_32B_PORTS; p++) begin : g_pack32
        lane_packer #(.IN_BYTES(4)) lane_packer_inst (
            .clk_ifc(clk_ifc), .rst_n(rst_n), .enable(ports_enable[N8+p]),
            .in_valid(in32_valid[p]), .in_data(in32_data[p]), .in_last(in32_last[p]),
            .word_valid(pk_valid[N8+p]), .word(pk_word[N8+p]),
            .word_keep(pk_keep[N8+p]), .word_last(pk_last[N8+p])
        );
    end

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : g_fifo
        frame_fifo frame_fifo_inst (
            .clk_ifc(clk_ifc), .rst_n(rst_n),
            .wr_valid(pk_valid[p]), .wr_word(pk_word[p]),
            .wr_keep(pk_keep[p]), .wr_last(pk_last[p]), .rd_en(ff_rd_en[p]),
            .frame_ready(ff_ready[p]), .rd_word(ff_word[p]), .rd_keep(ff_keep[p]),
            .rd_last(ff_last[p]), .overflow(buf_overflow[p])
        );
    end

    frame_arbiter frame_arbiter_inst (
        .clk_ifc(clk_ifc), .rst_n(rst_n),
        .frame_ready(ff_ready), .rd_word(ff_word), .rd_keep(ff_keep), .rd_last(ff_last),
        .rd_en(ff_rd_en), .out_valid(out_valid), .out_data(out_data),
        .out_keep(out_keep), .out_last(out_last), .out_port(out_port)
    );

    port_stats port_stats_inst (
        .clk_ifc(clk_ifc), .rst_n(rst_n),
        .frame_seen(frame_seen), .drop_seen(buf_overflow), .cnts_clear(cnts_clear),
        .frame_cnt(frame_cnt), .drop_cnt(drop_cnt)
    );

endmodule

/* tb/ingress_aggregator_checker.sv */
/* Converged bus checker
   Assertions on byte order, keep shape and whole-frame port tagging */

`timescale 1ns/1ps

`include "ingress_config.svh"

module ingress_aggregator_checker
    import ingress_pkg::*;
(
    input logic      clk_ifc,
    input logic      rst_n,
    input logic      out_valid,
    input bus_word_u out_data,
    input keep_t     out_keep,
    input logic      out_last,
    input port_idx_t out_port
);

    int         fail_count = 0;
    logic [7:0] byte_pos;
    logic       in_frame;
    port_idx_t  frame_port;
    logic       data_ok;

    // Byte b of every frame carries b mod 256
    always_comb begin
        data_ok = 1'b1;
        for (int b = 0; b < `ING_BUS_BYTES; b++) begin
            if (out_keep[b] && out_data.bytes[b] != byte_pos + 8'(b)) begin
                data_ok = 1'b0;
            end
        end
    end

    // Offset and owner of the frame currently on the bus
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            byte_pos   <= '0;
            in_frame   <= 1'b0;
            frame_port <= '0;
        end else if (out_valid) begin
            byte_pos   <= out_last ? 8'd0 : byte_pos + 8'(`ING_BUS_BYTES);
            in_frame   <= !out_last;
            frame_port <= out_port;
        end
    end

    a_data: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid |-> data_ok)
        else begin
            fail_count++;
            $error("Output byte out of sequence at frame offset %0d", $sampled(byte_pos));
        end

    a_keep_full: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid && !out_last |-> out_keep == '1)
        else begin
            fail_count++;
            $error("Keep not all ones on a middle word");
        end

    // Last word keep is nonzero and packed from bit 0
    a_keep_last: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid && out_last |-> out_keep != '0 && ((out_keep + 8'd1) & out_keep) == '0)
        else begin
            fail_count++;
            $error("Keep on a last word is empty or not contiguous");
        end

    a_no_interleave: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid && in_frame |-> out_port == frame_port)
        else begin
            fail_count++;
            $error("Frames interleaved on the converged bus");
        end

endmodule

bind ingress_aggregator ingress_aggregator_checker checker_inst (
    .clk_ifc   (clk_ifc),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_keep  (out_keep),
    .out_last  (out_last),
    .out_port  (out_port)
);

/* tb/ingress_aggregator_tb.sv */
/* Ingress aggregator testbench
   Random-length frames on all ports with tag, enable, overflow and clear checks */

`timescale 1ns/1ps

`include "ingress_config.svh"

module ingress_aggregator_tb
    import ingress_pkg::*;
();

    localparam int NP  = `ING_NUM_PORTS;
    localparam int N8  = `ING_NUM_8B_PORTS;
    localparam int N32 = `ING_NUM_32B_PORTS;

    logic                 clk_ifc = 1'b0;
    logic                 rst_n;
    logic [NP-1:0]        ports_enable;
    logic [NP-1:0]        cnts_clear;
    logic [N8-1:0]        in8_valid;
    logic [N8-1:0][7:0]   in8_data;
    logic [N8-1:0]        in8_last;
    logic [N32-1:0]       in32_valid;
    logic [N32-1:0][31:0] in32_data;
    logic [N32-1:0]       in32_last;
    logic                 out_valid;
    bus_word_u            out_data;
    keep_t                out_keep;
    logic                 out_last;
    port_idx_t            out_port;
    cnt_t                 frame_cnt [NP];
    cnt_t                 drop_cnt [NP];
    cnt_t                 drop_prev [NP];
    logic [NP-1:0]        buf_overflow;

    logic [31:0] lfsr;
    string       test_name;
    int          phase;
    port_idx_t   exp_port;
    int          errors = 0;
    int          timeouts = 0;
    int          sent [NP] = '{default: 0};
    int          base [NP];
    int          out_frames [NP] = '{default: 0};
    int          lens [NP][8];
    cnt_t        held_cnt;

    always #4 clk_ifc = ~clk_ifc;

    ingress_aggregator ingress_aggregator_inst (.*);

    // Count frames leaving per port and keep the drop counts of the previous cycle
    always @(posedge clk_ifc) begin
        if (out_valid && out_last) out_frames[out_port] <= out_frames[out_port] + 1;
        drop_prev <= drop_cnt;
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////

    a_tag: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        phase == 2 && out_valid |-> out_port == exp_port)
        else begin
            errors++;
            $display("ERROR %s: out_port expected %0d, actual %0d",
                     test_name, $sampled(exp_port), $sampled(out_port));
        end

    // Port 1 is the disabled one in the enable test
    a_disabled: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        phase == 4 && out_valid |-> out_port != 2'd1)
        else begin
            errors++;
            $display("ERROR %s: out_port expected other than 1, actual %0d",
                     test_name, $sampled(out_port));
        end

    for (genvar p = 0; p < NP; p++) begin : g_cnt_checks
        a_drop: assert property (@(posedge clk_ifc) disable iff (!rst_n)
            buf_overflow[p] && !cnts_clear[p] |=> drop_cnt[p] == drop_prev[p] + 1'b1)
            else begin
                errors++;
                $display("ERROR %s: drop_cnt[%0d] expected %0d, actual %0d", test_name, p,
                         $sampled(drop_prev[p]) + 1, $sampled(drop_cnt[p]));
            end

        a_clear: assert property (@(posedge clk_ifc) disable iff (!rst_n)
            cnts_clear[p] |=> frame_cnt[p] == '0 && drop_cnt[p] == '0)
            else begin
                errors++;
                $display("ERROR %s: port %0d counters expected 0/0, actual %0d/%0d", test_name,
                         p, $sampled(frame_cnt[p]), $sampled(drop_cnt[p]));
            end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // Length from 8 to max_bytes in whole port words
    function automatic int rand_len(input int port, input int max_bytes);
        int len;
        len = 8 + take_bits(8) % (max_bytes - 7);
        return (port < N8) ? len : len - len % 4;
    endfunction

    // Starts 1 ns after an edge and returns at the same phase
    task automatic send_frame(input int port, input int nbytes);
        int q;
        q = port - N8;
        for (int b = 0; b < nbytes; b += (port < N8) ? 1 : 4) begin
            if (port < N8) begin
                in8_valid[port] = 1'b1;
                in8_data[port]  = 8'(b);
                in8_last[port]  = (b + 1 == nbytes);
            end else begin
                in32_valid[q] = 1'b1;
                in32_data[q]  = {8'(b + 3), 8'(b + 2), 8'(b + 1), 8'(b)};
                in32_last[q]  = (b + 4 == nbytes);
            end
            @(posedge clk_ifc);
            #1;
        end
        if (port < N8) begin
            in8_valid[port] = 1'b0;
            in8_last[port]  = 1'b0;
        end else begin
            in32_valid[q] = 1'b0;
            in32_last[q]  = 1'b0;
        end
        sent[port]++;
    endtask

    task automatic send_burst(input int port, input int count);
        for (int k = 0; k < count; k++) send_frame(port, lens[port][k]);
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout in %s while waiting for %s", test_name, what);
    endtask

    task automatic wait_frame_out(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk_ifc);
            #1;
            n++;
        end while (!(out_valid && out_last) && n < limit);
        if (out_valid && out_last) begin
            // The last word is sampled on the next edge
            @(posedge clk_ifc);
            #1;
        end else begin
            note_timeout("the end of a frame");
        end
    endtask

    // Drained once the bus has been idle for 64 cycles
    task automatic wait_quiet(input int limit);
        int n;
        int idle;
        n = 0;
        idle = 0;
        while (idle < 64 && n < limit) begin
            @(posedge clk_ifc);
            #1;
            n++;
            idle = out_valid ? 0 : idle + 1;
        end
        if (idle < 64) note_timeout("the output to go idle");
    endtask

    task automatic pulse_clear(input logic [NP-1:0] mask);
        cnts_clear = mask;
        @(posedge clk_ifc);
        #1;
        cnts_clear = '0;
    endtask

    task automatic check_value(input string what, input int port, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("ERROR %s: %s port %0d expected %0d, actual %0d",
                     test_name, what, port, exp, act);
        end
    endtask

    task automatic start_counts(input int max_bytes);
        for (int p = 0; p < NP; p++) begin
            base[p] = out_frames[p];
            sent[p] = 0;
            for (int k = 0; k < 8; k++) lens[p][k] = rand_len(p, max_bytes);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        ports_enable = '1;
        cnts_clear   = '0;
        in8_valid    = '0;
        in8_data     = '0;
        in8_last     = '0;
        in32_valid   = '0;
        in32_data    = '0;
        in32_last    = '0;
        lfsr         = 32'h7895_4d4e;
        phase        = 0;
        exp_port     = '0;
        test_name    = "reset";
        repeat (2) @(posedge clk_ifc);
        #1;
        rst_n = 1'b1;

        // One frame at a time on each port in turn
        test_name = "port_tagging";
        phase     = 2;
        for (int p = 0; p < NP; p++) begin
            exp_port = port_idx_t'(p);
            send_frame(p, rand_len(p, 200));
            wait_frame_out(1000);
        end

        test_name = "whole_frames";
        phase     = 3;
        pulse_clear('1);
        start_counts(64);
        fork
            send_burst(0, 8);
            send_burst(1, 8);
            send_burst(2, 8);
            send_burst(3, 8);
        join
        wait_quiet(5000);
        for (int p = 0; p < NP; p++) begin
            check_value("frame_cnt", p, sent[p], int'(frame_cnt[p]));
            check_value("output frames", p, sent[p], out_frames[p] - base[p]);
        end

        test_name    = "enable";
        phase        = 4;
        ports_enable = 4'b1101;
        held_cnt     = frame_cnt[1];
        start_counts(64);
        fork
            send_burst(0, 4);
            send_burst(1, 4);
            send_burst(2, 4);
            send_burst(3, 4);
        join
        wait_quiet(5000);
        check_value("frame_cnt", 1, int'(held_cnt), int'(frame_cnt[1]));
        ports_enable = '1;

        // Two full-rate 32-bit streams outrun the bus
        test_name = "overflow";
        phase     = 6;
        pulse_clear('1);
        start_counts(200);
        fork
            repeat (100) send_frame(2, 200);
            repeat (100) send_frame(3, 200);
        join
        wait_quiet(10000);
        for (int p = N8; p < NP; p++) begin
            check_value("output frames", p, int'(frame_cnt[p]) - int'(drop_cnt[p]),
                        out_frames[p] - base[p]);
        end
        assert (int'(drop_cnt[2]) + int'(drop_cnt[3]) != 0) else begin
            errors++;
            $display("No FIFO overflow happened during the %s test", test_name);
        end

        test_name = "counter_clear";
        phase     = 5;
        pulse_clear('1);
        repeat (2) @(posedge clk_ifc);
        #1;

        $display("Summary: %0d check errors, %0d timeouts, %0d checker assertion failures",
                 errors, timeouts, ingress_aggregator_inst.checker_inst.fail_count);
        if (errors == 0 && timeouts == 0 &&
            ingress_aggregator_inst.checker_inst.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* ingress_aggregator.f */
+incdir+src
src/ingress_pkg.sv
src/lane_packer.sv
src/frame_fifo.sv
src/frame_arbiter.sv
src/port_stats.sv
src/ingress_aggregator.sv
tb/ingress_aggregator_checker.sv
tb/ingress_aggregator_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the ingress aggregator testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module ingress_aggregator_tb \
    -f ingress_aggregator.f || { echo "Build failed"; exit 1; }
./obj_dir/Vingress_aggregator_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && echo "Simulation failed" && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
